//--- design/daq_pkg.sv
// System sizing for the data-acquisition control path.
// Import wherever channel counts or clock rates are needed.

package daq_pkg;

  //////////////////////////////
  // channel sizing
  //////////////////////////////

  // one LMH6401 per input channel
  localparam int CHANNELS = 8;

  localparam int CHAN_IDX_W = $clog2(CHANNELS);

  typedef logic [CHAN_IDX_W-1:0] chan_idx_t;

  //////////////////////////////
  // clocking
  //////////////////////////////

  // processing-system clock, the only domain in this path
  localparam int PS_CLK_FREQ = 100_000_000;

  // target sck rate for the amplifier config bus
  localparam int SPI_CLK_FREQ = 1_000_000;

endpackage

//--- design/lmh6401_pkg.sv
// LMH6401 SPI frame format and serializer timing constants.
// Shared by the command queue, the shifter and the top level.

package lmh6401_pkg;

  //////////////////////////////
  // frame format
  //////////////////////////////

  // 16-bit frame, sent MSB first, content is opaque here
  localparam int FRAME_BITS = 16;

  typedef logic [FRAME_BITS-1:0] spi_word_t;

  //////////////////////////////
  // sck timing
  //////////////////////////////

  // ps_clk cycles per sck half period
  localparam int SCK_HALF_CYCLES = daq_pkg::PS_CLK_FREQ / (2 * daq_pkg::SPI_CLK_FREQ);

  localparam int HALF_CNT_W = $clog2(SCK_HALF_CYCLES);

  // wide enough to hold FRAME_BITS itself
  localparam int BIT_CNT_W = $clog2(FRAME_BITS) + 1;

  //////////////////////////////
  // command queue
  //////////////////////////////

  localparam int CMD_QUEUE_DEPTH = 4;

  localparam int Q_PTR_W = $clog2(CMD_QUEUE_DEPTH);

  // occupancy needs to reach CMD_QUEUE_DEPTH
  localparam int Q_CNT_W = $clog2(CMD_QUEUE_DEPTH + 1);

  // serializer FSM
  typedef enum logic [2:0] {
    SPI_IDLE,
    SPI_SETUP,
    SPI_SHIFT,
    SPI_HOLD,
    SPI_GAP
  } spi_state_e;

endpackage

//--- design/lmh6401_cmd_queue.sv
// Small FIFO of pending gain commands, frame word plus channel index.
// Host pushes with valid/ready, the serializer pops the head entry.
// Push and pop may happen in the same cycle.

`timescale 1ns/1ps

module lmh6401_cmd_queue (
  input  logic                   ps_clk,
  input  logic                   arst_n,
  input  lmh6401_pkg::spi_word_t cmd_data,
  input  daq_pkg::chan_idx_t     cmd_chan,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  output lmh6401_pkg::spi_word_t q_data,
  output daq_pkg::chan_idx_t     q_chan,
  output logic                   q_valid,
  input  logic                   frame_ready
);
  import daq_pkg::*;
  import lmh6401_pkg::*;

  // storage
  spi_word_t data_mem [CMD_QUEUE_DEPTH];
  chan_idx_t chan_mem [CMD_QUEUE_DEPTH];

  logic [Q_PTR_W-1:0] wr_ptr;
  logic [Q_PTR_W-1:0] rd_ptr;
  logic [Q_CNT_W-1:0] count;
  logic               push;
  logic               pop;

  // ready only looks at occupancy, not at a pop in this cycle
  assign cmd_ready = (count != Q_CNT_W'(CMD_QUEUE_DEPTH));
  assign q_valid   = (count != '0);

  assign push = cmd_valid && cmd_ready;
  assign pop  = q_valid && frame_ready;

  // head entry
  assign q_data = data_mem[rd_ptr];
  assign q_chan = chan_mem[rd_ptr];

  always_ff @(posedge ps_clk) begin
    if (push) begin
      data_mem[wr_ptr] <= cmd_data;
      chan_mem[wr_ptr] <= cmd_chan;
    end
  end

  //////////////////////////////
  // pointers and occupancy
  //////////////////////////////

  always_ff @(posedge ps_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        if (wr_ptr == Q_PTR_W'(CMD_QUEUE_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr == Q_PTR_W'(CMD_QUEUE_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge ps_clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        // both or neither, occupancy unchanged
        default: count <= count;
      endcase
    end
  end

endmodule

//--- design/lmh6401_spi_shifter.sv
// SPI mode 0 serializer for the LMH6401 gain amplifiers.
// Takes one frame from the queue, selects the addressed chip and shifts
// the word out MSB first with sck idle low. All pins are registered.

`timescale 1ns/1ps

module lmh6401_spi_shifter (
  input  logic                         ps_clk,
  input  logic                         arst_n,
  input  lmh6401_pkg::spi_word_t       q_data,
  input  daq_pkg::chan_idx_t           q_chan,
  input  logic                         q_valid,
  output logic                         frame_ready,
  output logic [daq_pkg::CHANNELS-1:0] lmh6401_cs_n,
  output logic                         lmh6401_sck,
  output logic                         lmh6401_sdi
);
  import daq_pkg::*;
  import lmh6401_pkg::*;

  spi_state_e            state;
  logic [HALF_CNT_W-1:0] half_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  spi_word_t             shift_reg;
  logic                  half_done;
  logic                  last_bit;
  logic                  start;
  logic                  bit_advance;

  // only take a new frame when fully idle
  assign frame_ready = (state == SPI_IDLE);
  assign start       = frame_ready && q_valid;

  assign half_done = (half_cnt == HALF_CNT_W'(SCK_HALF_CYCLES - 1));
  assign last_bit  = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

  // end of a high half with more bits to go
  assign bit_advance = (state == SPI_SHIFT) && half_done && lmh6401_sck && !last_bit;

  //////////////////////////////
  // half-period timer
  //////////////////////////////

  // runs in every state but idle, restarts each half period
  always_ff @(posedge ps_clk or negedge arst_n) begin
    if (!arst_n) begin
      half_cnt <= '0;
    end else if (state == SPI_IDLE || half_done) begin
      half_cnt <= '0;
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  //////////////////////////////
  // frame data
  //////////////////////////////

  // MSB of shift_reg always matches sdi while shifting
  always_ff @(posedge ps_clk) begin
    if (start) begin
      shift_reg <= q_data;
    end else if (bit_advance) begin
      shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b0};
    end
  end

  //////////////////////////////
  // control FSM and pins
  //////////////////////////////

  always_ff @(posedge ps_clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= SPI_IDLE;
      bit_cnt      <= '0;
      lmh6401_cs_n <= '1;
      lmh6401_sck  <= 1'b0;
      lmh6401_sdi  <= 1'b0;
    end else begin
      case (state)
        SPI_IDLE: begin
          if (start) begin
            state        <= SPI_SETUP;
            bit_cnt      <= '0;
            // one-hot select of the addressed amplifier
            lmh6401_cs_n <= ~(CHANNELS'(1) << q_chan);
            lmh6401_sdi  <= q_data[FRAME_BITS-1];
          end
        end
        // cs low, first bit already on sdi
        SPI_SETUP: begin
          if (half_done) begin
            state <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          if (half_done) begin
            if (!lmh6401_sck) begin
              // rising edge, slave samples here
              lmh6401_sck <= 1'b1;
            end else begin
              lmh6401_sck <= 1'b0;
              if (last_bit) begin
                state <= SPI_HOLD;
              end else begin
                // next bit at the start of the low half
                bit_cnt     <= bit_cnt + 1'b1;
                lmh6401_sdi <= shift_reg[FRAME_BITS-2];
              end
            end
          end
        end
        SPI_HOLD: begin
          if (half_done) begin
            state        <= SPI_GAP;
            lmh6401_cs_n <= '1;
            lmh6401_sdi  <= 1'b0;
          end
        end
        // bus idle before the next frame
        SPI_GAP: begin
          if (half_done) begin
            state <= SPI_IDLE;
          end
        end
        default: begin
          state        <= SPI_IDLE;
          lmh6401_cs_n <= '1;
          lmh6401_sck  <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- design/lmh6401_ctrl_top.sv
// Preamp gain control path, host commands in and LMH6401 SPI pins out.
// A command queue feeds one SPI serializer, all on ps_clk.

`timescale 1ns/1ps

module lmh6401_ctrl_top (
  input  logic                         ps_clk,
  input  logic                         arst_n,
  input  lmh6401_pkg::spi_word_t       cmd_data,
  input  daq_pkg::chan_idx_t           cmd_chan,
  input  logic                         cmd_valid,
  output logic                         cmd_ready,
  output logic [daq_pkg::CHANNELS-1:0] lmh6401_cs_n,
  output logic                         lmh6401_sck,
  output logic                         lmh6401_sdi
);
  import daq_pkg::*;
  import lmh6401_pkg::*;

  // queue head towards the serializer
  spi_word_t q_data;
  chan_idx_t q_chan;
  logic      q_valid;
  logic      frame_ready;

  lmh6401_cmd_queue i_cmd_queue (
    .ps_clk      (ps_clk),
    .arst_n      (arst_n),
    .cmd_data    (cmd_data),
    .cmd_chan    (cmd_chan),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .q_data      (q_data),
    .q_chan      (q_chan),
    .q_valid     (q_valid),
    .frame_ready (frame_ready)
  );

  lmh6401_spi_shifter i_spi_shifter (
    .ps_clk       (ps_clk),
    .arst_n       (arst_n),
    .q_data       (q_data),
    .q_chan       (q_chan),
    .q_valid      (q_valid),
    .frame_ready  (frame_ready),
    .lmh6401_cs_n (lmh6401_cs_n),
    .lmh6401_sck  (lmh6401_sck),
    .lmh6401_sdi  (lmh6401_sdi)
  );

endmodule

//--- dv/tb_lmh6401_ctrl.sv
// Testbench for the LMH6401 gain control path.
// Drives random host commands, decodes the SPI pins with a bus monitor and
// checks every frame against a queue of accepted commands.

`timescale 1ns/1ps

module tb_lmh6401_ctrl;
  import daq_pkg::*;
  import lmh6401_pkg::*;

  localparam int          CLK_PERIOD  = 100;
  localparam int          SEND_LIMIT  = 10_000;
  localparam int          DRAIN_LIMIT = 20_000;
  localparam int          NUM_B2B     = 40;
  // long enough for a stray frame to pull a chip select low
  localparam int          IDLE_WATCH  = 4 * SCK_HALF_CYCLES;
  localparam logic [31:0] LFSR_SEED   = 32'h2961_40bd;
  // x^32 + x^30 + x^26 + x^25 + 1
  localparam logic [31:0] LFSR_TAPS   = 32'hA300_0000;

  logic                ps_clk;
  logic                arst_n;
  spi_word_t           cmd_data;
  chan_idx_t           cmd_chan;
  logic                cmd_valid;
  logic                cmd_ready;
  logic [CHANNELS-1:0] lmh6401_cs_n;
  logic                lmh6401_sck;
  logic                lmh6401_sdi;

  // reference model of accepted commands in arrival order
  spi_word_t   exp_word_q[$];
  chan_idx_t   exp_chan_q[$];
  int          last_wait   = 0;
  logic [31:0] lfsr_state  = LFSR_SEED;
  string       cur_test    = "reset";

  // bus monitor state
  logic        prev_sck    = 1'b0;
  logic        in_frame    = 1'b0;
  spi_word_t   rx_word     = '0;
  chan_idx_t   rx_chan     = '0;
  int          rx_edges    = 0;
  int          frames_seen = 0;
  int          cs_low_cnt  = 0;

  lmh6401_ctrl_top i_lmh6401_ctrl_top (
    .ps_clk       (ps_clk),
    .arst_n       (arst_n),
    .cmd_data     (cmd_data),
    .cmd_chan     (cmd_chan),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .lmh6401_cs_n (lmh6401_cs_n),
    .lmh6401_sck  (lmh6401_sck),
    .lmh6401_sdi  (lmh6401_sdi)
  );

  initial begin
    ps_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ps_clk = ~ps_clk;
  end

  //////////////////////////////
  // failure reporting
  //////////////////////////////

  task automatic stop_run();
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic report_failure(input string why);
    $display("Error: %s", why);
    stop_run();
  endtask

  task automatic compare_word(input string name, input spi_word_t exp, input spi_word_t act);
    if (act !== exp) begin
      $display("** Error [%s] expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic compare_chan(input string name, input chan_idx_t exp, input chan_idx_t act);
    if (act !== exp) begin
      $display("** Error [%s] expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic compare_logic(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error [%s] expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  //////////////////////////////
  // random numbers
  //////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // one LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits       = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic random_cmd(output spi_word_t word, output chan_idx_t chan);
    logic [31:0] bits;
    take_bits(FRAME_BITS, bits);
    word = bits[FRAME_BITS-1:0];
    take_bits(CHAN_IDX_W, bits);
    chan = bits[CHAN_IDX_W-1:0];
  endtask

  //////////////////////////////
  // host side driver
  //////////////////////////////

  // enters and leaves 1 ns after a rising edge
  task automatic send_cmd(input spi_word_t word, input chan_idx_t chan);
    int waited;
    waited    = 0;
    cmd_data  = word;
    cmd_chan  = chan;
    cmd_valid = 1'b1;
    // cmd_ready only moves on a clock edge, so it is stable here
    while (!cmd_ready) begin
      waited++;
      if (waited > SEND_LIMIT) begin
        report_failure("timed out waiting for cmd_ready");
      end
      @(posedge ps_clk);
      #1;
    end
    @(posedge ps_clk);
    exp_word_q.push_back(word);
    exp_chan_q.push_back(chan);
    last_wait = waited;
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge ps_clk);
      #1;
    end
  endtask

  task automatic wait_frame_start();
    int waited;
    waited = 0;
    while (&lmh6401_cs_n) begin
      waited++;
      if (waited > SEND_LIMIT) begin
        report_failure("timed out waiting for a chip select to go low");
      end
      @(posedge ps_clk);
      #1;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_word_q.size() != 0 || in_frame) begin
      waited++;
      if (waited > DRAIN_LIMIT) begin
        report_failure("timed out waiting for pending frames on the SPI bus");
      end
      @(posedge ps_clk);
      #1;
    end
  endtask

  // any frame after the drain would be one too many
  task automatic watch_bus_idle(input string name, input int n);
    repeat (n) begin
      @(posedge ps_clk);
      #1;
      compare_logic($sformatf("%s cs_n all high", name), 1'b1, &lmh6401_cs_n);
      compare_logic($sformatf("%s sck low", name), 1'b0, lmh6401_sck);
    end
  endtask

  //////////////////////////////
  // SPI bus monitor
  //////////////////////////////

  function automatic int count_low(input logic [CHANNELS-1:0] cs);
    int n;
    n = 0;
    for (int i = 0; i < CHANNELS; i++) begin
      if (!cs[i]) begin
        n++;
      end
    end
    return n;
  endfunction

  function automatic chan_idx_t low_index(input logic [CHANNELS-1:0] cs);
    chan_idx_t idx;
    idx = '0;
    for (int i = 0; i < CHANNELS; i++) begin
      if (!cs[i]) begin
        idx = chan_idx_t'(i);
      end
    end
    return idx;
  endfunction

  task automatic check_frame();
    spi_word_t exp_word;
    chan_idx_t exp_chan;
    if (exp_word_q.size() == 0) begin
      report_failure("frame seen on the SPI bus with no pending command");
    end
    if (rx_edges != FRAME_BITS) begin
      $display("** Error [%s frame %0d sck edges] expected %0d, actual %0d",
               cur_test, frames_seen, FRAME_BITS, rx_edges);
      stop_run();
    end
    exp_word = exp_word_q.pop_front();
    exp_chan = exp_chan_q.pop_front();
    compare_word($sformatf("%s frame %0d word", cur_test, frames_seen), exp_word, rx_word);
    compare_chan($sformatf("%s frame %0d chan", cur_test, frames_seen), exp_chan, rx_chan);
    frames_seen++;
  endtask

  // sampled mid cycle away from the registered pin updates
  always @(negedge ps_clk) begin
    if (arst_n) begin
      cs_low_cnt = count_low(lmh6401_cs_n);
      if (cs_low_cnt > 1) begin
        report_failure("more than one chip select low at the same time");
      end else if (cs_low_cnt == 1) begin
        if (!in_frame) begin
          in_frame = 1'b1;
          rx_chan  = low_index(lmh6401_cs_n);
          rx_word  = '0;
          rx_edges = 0;
        end else if (low_index(lmh6401_cs_n) != rx_chan) begin
          report_failure("chip select moved to another channel inside a frame");
        end
        // sdi is held through the high half
        if (lmh6401_sck && !prev_sck) begin
          rx_word = {rx_word[FRAME_BITS-2:0], lmh6401_sdi};
          rx_edges++;
        end
      end else begin
        if (lmh6401_sck) begin
          report_failure("sck high while every chip select is high");
        end
        if (in_frame) begin
          in_frame = 1'b0;
          check_frame();
        end
      end
      prev_sck = lmh6401_sck;
    end
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    spi_word_t   word;
    chan_idx_t   chan;
    logic [31:0] bits;
    arst_n    = 1'b0;
    cmd_valid = 1'b0;
    cmd_data  = '0;
    cmd_chan  = '0;
    repeat (5) @(posedge ps_clk);
    #1;
    arst_n = 1'b1;

    cur_test = "reset";
    compare_logic("reset cs_n all high", 1'b1, &lmh6401_cs_n);
    compare_logic("reset sck low", 1'b0, lmh6401_sck);
    compare_logic("reset sdi low", 1'b0, lmh6401_sdi);
    compare_logic("reset cmd_ready high", 1'b1, cmd_ready);

    cur_test = "single_command";
    random_cmd(word, chan);
    send_cmd(word, chan);
    wait_drain();
    watch_bus_idle("single_command", IDLE_WATCH);

    // gaps of 0 to 2250 cycles straddle the frame length
    cur_test = "back_to_back";
    for (int i = 0; i < NUM_B2B; i++) begin
      random_cmd(word, chan);
      send_cmd(word, chan);
      take_bits(4, bits);
      idle_cycles(int'(bits[3:0]) * 150);
    end
    wait_drain();

    cur_test = "back_pressure";
    random_cmd(word, chan);
    send_cmd(word, chan);
    wait_frame_start();
    // queue is empty now and no pop happens until this frame ends
    for (int i = 0; i < CMD_QUEUE_DEPTH; i++) begin
      random_cmd(word, chan);
      send_cmd(word, chan);
      compare_logic($sformatf("back_pressure cmd %0d accepted at once", i), 1'b1,
                    last_wait == 0);
    end
    compare_logic("back_pressure cmd_ready low when full", 1'b0, cmd_ready);
    random_cmd(word, chan);
    send_cmd(word, chan);
    compare_logic("back_pressure extra cmd held off", 1'b1, last_wait > 0);
    random_cmd(word, chan);
    send_cmd(word, chan);
    wait_drain();

    cur_test = "bus_idle";
    watch_bus_idle("bus_idle", IDLE_WATCH);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- verilog.f
design/daq_pkg.sv
design/lmh6401_pkg.sv
design/lmh6401_cmd_queue.sv
design/lmh6401_spi_shifter.sv
design/lmh6401_ctrl_top.sv
dv/tb_lmh6401_ctrl.sv

//--- Makefile
# Verilator flow for the LMH6401 gain control path

VERILATOR  ?= verilator
FILELIST   := verilog.f
TOP        := tb_lmh6401_ctrl
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation PASSED
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: all lint build sim clean

all: sim

# static checks over the whole file list
lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

# compile testbench and RTL into one executable
build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

# run and decide pass or fail from the printed output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
